// File: csr_exception_regs.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_exception_regs (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit,
    input  csr_pkg::csr_addr_e commit_addr,
    input  csr_pkg::csr_word_t commit_data,
    input  logic               exception,
    input  logic               ertn,
    input  logic [6:0]         expcode,
    input  csr_pkg::csr_word_t era_in,
    input  csr_pkg::csr_word_t badv_in,
    input  logic               wen_era,
    input  logic               wen_badv,
    input  logic [7:0]         hw_int,
    input  logic               timer_int,
    csr_view_if.source         view
);
    import csr_pkg::*;

    logic                   exception_q;
    logic                   entry_upd;
    logic                   commit_upd;
    logic [`CRMD_PLV]       plv_q;
    logic                   ie_q;
    logic                   da_q;
    logic                   pg_q;
    logic [`PRMD_PPLV]      pplv_q;
    logic                   pie_q;
    logic [`ECFG_LIE]       lie_q;
    logic [`ESTAT_IS_SOFT]  is_soft_q;
    logic [`ESTAT_ECODE]    ecode_q;
    logic [`ESTAT_ESUBCODE] esubcode_q;
    logic [`EENTRY_VA]      eentry_va_q;
    csr_word_t              era_q;
    csr_word_t              badv_q;
    csr_word_t              save_q [4];

    // Entry is the first cycle of exception, ertn wins over both
    assign entry_upd  = exception && !exception_q && !ertn;
    assign commit_upd = commit && !ertn && !(exception && !exception_q);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exception_q <= 1'b0;
        end else begin
            exception_q <= exception;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
            da_q  <= 1'b1;
            pg_q  <= 1'b0;
        end else if (ertn) begin
            plv_q <= pplv_q;
            ie_q  <= pie_q;
        end else if (entry_upd) begin
            plv_q <= '0;
            ie_q  <= 1'b0;
        end else if (commit_upd && commit_addr == CSR_CRMD) begin
            plv_q <= commit_data[`CRMD_PLV];
            ie_q  <= commit_data[`CRMD_IE];
            // Only direct or mapped mode, never both or neither
            if (commit_data[`CRMD_PG] ^ commit_data[`CRMD_DA]) begin
                pg_q <= commit_data[`CRMD_PG];
                da_q <= commit_data[`CRMD_DA];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            pplv_q <= '0;
            pie_q  <= 1'b0;
        end else if (entry_upd) begin
            pplv_q <= plv_q;
            pie_q  <= ie_q;
        end else if (commit_upd && commit_addr == CSR_PRMD) begin
            pplv_q <= commit_data[`PRMD_PPLV];
            pie_q  <= commit_data[`PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            lie_q       <= '0;
            is_soft_q   <= '0;
            ecode_q     <= '0;
            esubcode_q  <= '0;
            eentry_va_q <= '0;
        end else begin
            if (commit_upd && commit_addr == CSR_ECFG) begin
                lie_q <= commit_data[`ECFG_LIE] & `ECFG_LIE_MASK;
            end
            if (entry_upd) begin
                ecode_q    <= expcode[`EXPCODE_ECODE];
                esubcode_q <= (expcode[`EXPCODE_ECODE] == '0) ? '0
                                                              : {8'b0, expcode[`EXPCODE_SUB]};
            end else if (commit_upd && commit_addr == CSR_ESTAT) begin
                is_soft_q <= commit_data[`ESTAT_IS_SOFT];
            end
            if (commit_upd && commit_addr == CSR_EENTRY) begin
                eentry_va_q <= commit_data[`EENTRY_VA];
            end
        end
    end

    // Pipeline loads beat CSR writes
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_q  <= '0;
            badv_q <= '0;
        end else begin
            if (wen_era) begin
                era_q <= era_in;
            end else if (commit_upd && commit_addr == CSR_ERA) begin
                era_q <= commit_data;
            end
            if (wen_badv) begin
                badv_q <= badv_in;
            end else if (commit_upd && commit_addr == CSR_BADV) begin
                badv_q <= commit_data;
            end
        end
    end

    // SAVE0-3 share the low address bits
    always_ff @(posedge clk) begin
        if (commit_upd && commit_addr inside {CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3}) begin
            save_q[commit_addr[1:0]] <= commit_data;
        end
    end

    always_comb begin
        view.crmd                     = '0;
        view.crmd[`CRMD_PLV]          = plv_q;
        view.crmd[`CRMD_IE]           = ie_q;
        view.crmd[`CRMD_DA]           = da_q;
        view.crmd[`CRMD_PG]           = pg_q;
        view.prmd                     = '0;
        view.prmd[`PRMD_PPLV]         = pplv_q;
        view.prmd[`PRMD_PIE]          = pie_q;
        view.ecfg                     = '0;
        view.ecfg[`ECFG_LIE]          = lie_q;
        view.estat                    = '0;
        view.estat[`ESTAT_IS_SOFT]    = is_soft_q;
        view.estat[`ESTAT_IS_HARD]    = hw_int;
        view.estat[`ESTAT_IS_TI]      = timer_int;
        view.estat[`ESTAT_ECODE]      = ecode_q;
        view.estat[`ESTAT_ESUBCODE]   = esubcode_q;
        view.eentry                   = '0;
        view.eentry[`EENTRY_VA]       = eentry_va_q;
    end

    assign view.era   = era_q;
    assign view.badv  = badv_q;
    assign view.save0 = save_q[0];
    assign view.save1 = save_q[1];
    assign view.save2 = save_q[2];
    assign view.save3 = save_q[3];

endmodule

// File: csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Register and address widths
`define CSR_WORD_W 32
`define CSR_ADDR_W 14

// CRMD fields
`define CRMD_PLV 1:0
`define CRMD_IE 2
`define CRMD_DA 3
`define CRMD_PG 4

// PRMD fields
`define PRMD_PPLV 1:0
`define PRMD_PIE 2

// ECFG local interrupt enables, bit 10 is reserved
`define ECFG_LIE 12:0
`define ECFG_LIE_MASK 13'b1_1011_1111_1111

// ESTAT fields
`define ESTAT_IS 12:0
`define ESTAT_IS_SOFT 1:0
`define ESTAT_IS_HARD 9:2
`define ESTAT_IS_TI 11
`define ESTAT_ECODE 21:16
`define ESTAT_ESUBCODE 30:22

// Exception code as given by the pipeline
`define EXPCODE_ECODE 5:0
`define EXPCODE_SUB 6

`define EENTRY_VA 31:6

// Timer fields
`define TCFG_EN 0
`define TCFG_PERIODIC 1
`define TCFG_INITVAL 31:2
`define TICLR_CLR 0

// Idle cycles a pending write waits before it commits
`define CSR_COMMIT_IDLE_CYCLES 3

`endif

// File: csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

    typedef logic [`CSR_WORD_W-1:0] csr_word_t;

    // Kept CSR addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // Write stage, one state per counted idle cycle
    typedef enum logic [1:0] {
        WR_IDLE  = 2'd0,
        WR_WAIT0 = 2'd1,
        WR_WAIT1 = 2'd2,
        WR_WAIT2 = 2'd3
    } wr_state_e;

endpackage

// File: csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_read_mux (
    input  csr_pkg::csr_addr_e addr,
    csr_view_if.reader         view,
    input  csr_pkg::csr_word_t tcfg,
    input  csr_pkg::csr_word_t tval,
    output csr_pkg::csr_word_t rdata,
    output logic               cpu_interrupt,
    output logic               idle_over
);
    import csr_pkg::*;

    logic [`ESTAT_IS] pending;

    always_comb begin
        unique case (addr)
            CSR_CRMD:   rdata = view.crmd;
            CSR_PRMD:   rdata = view.prmd;
            CSR_ECFG:   rdata = view.ecfg;
            CSR_ESTAT:  rdata = view.estat;
            CSR_ERA:    rdata = view.era;
            CSR_BADV:   rdata = view.badv;
            CSR_EENTRY: rdata = view.eentry;
            CSR_SAVE0:  rdata = view.save0;
            CSR_SAVE1:  rdata = view.save1;
            CSR_SAVE2:  rdata = view.save2;
            CSR_SAVE3:  rdata = view.save3;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            // TICLR is write-only
            CSR_TICLR:  rdata = '0;
            default:    rdata = '0;
        endcase
    end

    // Enabled and pending interrupt lines
    assign pending       = view.ecfg[`ECFG_LIE] & view.estat[`ESTAT_IS];
    assign cpu_interrupt = view.crmd[`CRMD_IE] && (pending != '0);

    // Any pending line ends idle, enabled or not
    assign idle_over = view.estat[`ESTAT_IS] != '0;

endmodule

// File: csr_timer.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_timer (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit,
    input  csr_pkg::csr_addr_e commit_addr,
    input  csr_pkg::csr_word_t commit_data,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic               timer_int
);
    import csr_pkg::*;

    logic                 en_q;
    logic                 periodic_q;
    logic [`TCFG_INITVAL] initval_q;
    csr_word_t            tval_q;
    logic                 ti_q;
    logic                 tcfg_wr;
    logic                 ticlr_wr;
    logic                 expire;

    assign tcfg_wr  = commit && commit_addr == CSR_TCFG;
    assign ticlr_wr = commit && commit_addr == CSR_TICLR && commit_data[`TICLR_CLR];
    // Counter reaches zero on this edge
    assign expire   = en_q && tval_q == 32'd1 && !tcfg_wr;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
            initval_q  <= '0;
        end else if (tcfg_wr) begin
            en_q       <= commit_data[`TCFG_EN];
            periodic_q <= commit_data[`TCFG_PERIODIC];
            initval_q  <= commit_data[`TCFG_INITVAL];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval_q <= '0;
        end else if (tcfg_wr) begin
            tval_q <= {2'b00, commit_data[`TCFG_INITVAL]};
        end else if (en_q) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 32'd1;
            end else if (periodic_q) begin
                tval_q <= {2'b00, initval_q};
            end
        end
    end

    // Clear on TICLR wins over a new expiry
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti_q <= 1'b0;
        end else if (ticlr_wr) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    always_comb begin
        tcfg                 = '0;
        tcfg[`TCFG_EN]       = en_q;
        tcfg[`TCFG_PERIODIC] = periodic_q;
        tcfg[`TCFG_INITVAL]  = initval_q;
    end

    assign tval      = tval_q;
    assign timer_int = ti_q;

endmodule

// File: csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wr_req,
    input  csr_pkg::csr_addr_e addr,
    input  csr_pkg::csr_word_t wdata,
    output csr_pkg::csr_word_t rdata,
    input  logic               d_idle,
    input  logic               flush,
    input  logic               exception,
    input  logic               ertn,
    input  logic [6:0]         expcode,
    input  csr_pkg::csr_word_t era_in,
    input  logic               wen_era,
    input  csr_pkg::csr_word_t badv_in,
    input  logic               wen_badv,
    input  logic [7:0]         hw_int,
    output logic               cpu_interrupt,
    output logic               idle_over,
    output csr_pkg::csr_word_t crmd,
    output csr_pkg::csr_word_t era,
    output csr_pkg::csr_word_t eentry
);
    import csr_pkg::*;

    logic      commit;
    csr_addr_e commit_addr;
    csr_word_t commit_data;
    csr_word_t tcfg;
    csr_word_t tval;
    logic      timer_int;

    csr_view_if view ();

    csr_write_stage u_write_stage (
        .clk         (clk),
        .aresetn     (aresetn),
        .wr_req      (wr_req),
        .addr        (addr),
        .wdata       (wdata),
        .d_idle      (d_idle),
        .flush       (flush),
        .commit      (commit),
        .commit_addr (commit_addr),
        .commit_data (commit_data)
    );

    csr_exception_regs u_exception_regs (
        .clk         (clk),
        .aresetn     (aresetn),
        .commit      (commit),
        .commit_addr (commit_addr),
        .commit_data (commit_data),
        .exception   (exception),
        .ertn        (ertn),
        .expcode     (expcode),
        .era_in      (era_in),
        .badv_in     (badv_in),
        .wen_era     (wen_era),
        .wen_badv    (wen_badv),
        .hw_int      (hw_int),
        .timer_int   (timer_int),
        .view        (view.source)
    );

    csr_timer u_timer (
        .clk         (clk),
        .aresetn     (aresetn),
        .commit      (commit),
        .commit_addr (commit_addr),
        .commit_data (commit_data),
        .tcfg        (tcfg),
        .tval        (tval),
        .timer_int   (timer_int)
    );

    csr_read_mux u_read_mux (
        .addr          (addr),
        .view          (view.reader),
        .tcfg          (tcfg),
        .tval          (tval),
        .rdata         (rdata),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    assign crmd   = view.crmd;
    assign era    = view.era;
    assign eentry = view.eentry;

endmodule

// File: csr_unit_props.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_props (
    input logic               clk,
    input logic               aresetn,
    input logic               commit,
    input logic               flush,
    input logic               exception,
    input logic               ertn,
    input logic               cpu_interrupt,
    input csr_pkg::csr_word_t crmd,
    input csr_pkg::wr_state_e wr_state
);
    import csr_pkg::*;

    int unsigned failures = 0;

    commit_one_cycle: assert property (@(posedge clk) disable iff (!aresetn)
        commit |=> !commit)
        else begin
            $error("commit stayed high for a second cycle");
            failures++;
        end

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[`CRMD_IE])
        else begin
            $error("cpu_interrupt raised with CRMD.IE clear");
            failures++;
        end

    // Entry drops to kernel level on the following edge
    entry_clears_plv: assert property (@(posedge clk) disable iff (!aresetn)
        $rose(exception) && !ertn |=> crmd[`CRMD_PLV] == 2'b00)
        else begin
            $error("CRMD.PLV not zero after exception entry");
            failures++;
        end

    flush_idles_stage: assert property (@(posedge clk) disable iff (!aresetn)
        flush |=> wr_state == WR_IDLE)
        else begin
            $error("write stage not idle after flush");
            failures++;
        end

endmodule

bind csr_unit csr_unit_props u_props (
    .clk           (clk),
    .aresetn       (aresetn),
    .commit        (commit),
    .flush         (flush),
    .exception     (exception),
    .ertn          (ertn),
    .cpu_interrupt (cpu_interrupt),
    .crmd          (crmd),
    .wr_state      (u_write_stage.state_q)
);

// File: csr_view_if.sv
`timescale 1ns/1ps

interface csr_view_if;
    import csr_pkg::*;

    csr_word_t crmd;
    csr_word_t prmd;
    csr_word_t ecfg;
    csr_word_t estat;
    csr_word_t era;
    csr_word_t badv;
    csr_word_t eentry;
    csr_word_t save0;
    csr_word_t save1;
    csr_word_t save2;
    csr_word_t save3;

    modport source (
        output crmd, prmd, ecfg, estat, era, badv, eentry, save0, save1, save2, save3
    );

    modport reader (
        input crmd, prmd, ecfg, estat, era, badv, eentry, save0, save1, save2, save3
    );

endinterface

// File: csr_write_stage.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_write_stage (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wr_req,
    input  csr_pkg::csr_addr_e addr,
    input  csr_pkg::csr_word_t wdata,
    input  logic               d_idle,
    input  logic               flush,
    output logic               commit,
    output csr_pkg::csr_addr_e commit_addr,
    output csr_pkg::csr_word_t commit_data
);
    import csr_pkg::*;

    localparam wr_state_e LAST_WAIT = wr_state_e'(`CSR_COMMIT_IDLE_CYCLES);

    wr_state_e state_q;
    wr_state_e state_d;
    csr_addr_e addr_q;
    csr_word_t data_q;

    assign commit      = (state_q == LAST_WAIT) && d_idle && !flush;
    assign commit_addr = addr_q;
    assign commit_data = data_q;

    always_comb begin
        state_d = state_q;
        if (flush) begin
            state_d = WR_IDLE;
        end else begin
            unique case (state_q)
                WR_IDLE:  if (wr_req) state_d = WR_WAIT0;
                WR_WAIT0: if (d_idle) state_d = WR_WAIT1;
                WR_WAIT1: if (d_idle) state_d = WR_WAIT2;
                // A request in the commit cycle starts a fresh wait
                WR_WAIT2: if (commit) state_d = wr_req ? WR_WAIT0 : WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state_q <= WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Newer request replaces the pending one
    always_ff @(posedge clk) begin
        if (wr_req && !flush) begin
            addr_q <= addr;
            data_q <= wdata;
        end
    end

endmodule

// File: sources.f
+incdir+.
csr_pkg.sv
csr_view_if.sv
csr_write_stage.sv
csr_exception_regs.sv
csr_timer.sv
csr_read_mux.sv
csr_unit.sv
csr_unit_props.sv
tb_csr_unit.sv

// File: tb_csr_unit.sv
`timescale 1ns/1ps
`include "csr_macros.svh"

module tb_csr_unit;
    import csr_pkg::*;

    localparam int RESET_CYCLES = 2;

    logic       clk = 1'b0;
    logic       aresetn;
    logic       wr_req;
    csr_addr_e  addr;
    csr_word_t  wdata;
    csr_word_t  rdata;
    logic       d_idle;
    logic       flush;
    logic       exception;
    logic       ertn;
    logic [6:0] expcode;
    csr_word_t  era_in;
    logic       wen_era;
    csr_word_t  badv_in;
    logic       wen_badv;
    logic [7:0] hw_int;
    logic       cpu_interrupt;
    logic       idle_over;
    csr_word_t  crmd;
    csr_word_t  era;
    csr_word_t  eentry;

    logic [15:0] lfsr_state = 16'd49583;
    string       test_name;
    int          test_errs;
    int          tests_ok;
    int          tests_bad;
    int          checks;

    // Reference model
    logic [1:0]  m_plv;
    logic        m_ie;
    logic        m_da;
    logic        m_pg;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_ecfg;
    logic [1:0]  m_soft;
    logic [5:0]  m_ecode;
    logic        m_esub;
    logic        m_ti;
    csr_word_t   m_era;
    csr_word_t   m_badv;
    csr_word_t   m_eentry;
    csr_word_t   m_tcfg;
    csr_word_t   m_save [4];

    csr_unit UUT (.*);

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic csr_word_t rand_bits(input int n);
        csr_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic csr_addr_e pick_addr(input csr_word_t sel);
        case (sel[2:0])
            3'd0: return CSR_SAVE0;
            3'd1: return CSR_SAVE1;
            3'd2: return CSR_SAVE2;
            3'd3: return CSR_SAVE3;
            3'd4: return CSR_ERA;
            3'd5: return CSR_BADV;
            3'd6: return CSR_EENTRY;
            default: return CSR_ECFG;
        endcase
    endfunction

    function automatic void model_write(input csr_addr_e a, input csr_word_t d);
        case (a)
            CSR_CRMD: begin
                m_plv = d[1:0];
                m_ie  = d[2];
                // PG and DA move only as a one-hot pair
                if (d[4] != d[3]) begin
                    m_pg = d[4];
                    m_da = d[3];
                end
            end
            CSR_PRMD: begin
                m_pplv = d[1:0];
                m_pie  = d[2];
            end
            CSR_ECFG:   m_ecfg = d[12:0] & 13'b1_1011_1111_1111;
            CSR_ESTAT:  m_soft = d[1:0];
            CSR_ERA:    m_era = d;
            CSR_BADV:   m_badv = d;
            CSR_EENTRY: m_eentry = {d[31:6], 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: m_save[a[1:0]] = d;
            CSR_TCFG:   m_tcfg = d;
            CSR_TICLR:  if (d[0]) m_ti = 1'b0;
            default: ;
        endcase
    endfunction

    function automatic logic [12:0] model_is();
        return {1'b0, m_ti, 1'b0, hw_int, m_soft};
    endfunction

    function automatic csr_word_t model_read(input csr_addr_e a);
        case (a)
            CSR_CRMD:   return {27'b0, m_pg, m_da, m_ie, m_plv};
            CSR_PRMD:   return {29'b0, m_pie, m_pplv};
            CSR_ECFG:   return {19'b0, m_ecfg};
            CSR_ESTAT:  return {9'b0, m_esub, m_ecode, 3'b0, model_is()};
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return m_save[a[1:0]];
            CSR_TCFG:   return m_tcfg;
            default:    return '0;
        endcase
    endfunction

    task automatic check_word(input string what, input csr_word_t exp, input csr_word_t act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", test_name, test_errs);
            tests_bad++;
        end
        test_errs = 0;
    endtask

    // Returns once the commit edge has passed, d_idle assumed high
    task automatic write_csr(input csr_addr_e a, input csr_word_t d);
        @(negedge clk);
        wr_req = 1'b1;
        addr   = a;
        wdata  = d;
        @(negedge clk);
        wr_req = 1'b0;
        repeat (3) @(negedge clk);
        model_write(a, d);
    endtask

    task automatic read_check(input string what, input csr_addr_e a);
        @(negedge clk);
        addr = a;
        #1;
        check_word(what, model_read(a), rdata);
    endtask

    task automatic raise_exception(input logic [6:0] code);
        @(negedge clk);
        exception = 1'b1;
        expcode   = code;
        @(negedge clk);
        exception = 1'b0;
        m_pplv  = m_plv;
        m_pie   = m_ie;
        m_plv   = 2'b00;
        m_ie    = 1'b0;
        m_ecode = code[5:0];
        m_esub  = (code[5:0] == 6'd0) ? 1'b0 : code[6];
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn  = 1'b0;
        m_plv = m_pplv;
        m_ie  = m_pie;
    endtask

    task automatic wait_tval(input csr_word_t target, input int limit, input string what);
        int n;
        n = 0;
        while (n < limit) begin
            @(negedge clk);
            addr = CSR_TVAL;
            #1;
            if (rdata === target) begin
                break;
            end
            n++;
        end
        if (n == limit) begin
            $display("timeout: TVAL did not reach %0d within %0d cycles during %s",
                     target, limit, what);
            test_errs++;
        end
    endtask

    initial begin
        csr_addr_e   a;
        csr_word_t   d;
        int          n;
        int          init;
        logic [12:0] pend;

        aresetn   = 1'b0;
        wr_req    = 1'b0;
        addr      = CSR_CRMD;
        wdata     = '0;
        d_idle    = 1'b1;
        flush     = 1'b0;
        exception = 1'b0;
        ertn      = 1'b0;
        expcode   = '0;
        era_in    = '0;
        wen_era   = 1'b0;
        badv_in   = '0;
        wen_badv  = 1'b0;
        hw_int    = '0;
        test_errs = 0;
        tests_ok  = 0;
        tests_bad = 0;
        checks    = 0;
        {m_plv, m_ie, m_pg, m_pplv, m_pie, m_ecfg, m_soft, m_ecode, m_esub, m_ti} = '0;
        m_da     = 1'b1;
        m_era    = '0;
        m_badv   = '0;
        m_eentry = '0;
        m_tcfg   = '0;
        for (int i = 0; i < 4; i++) begin
            m_save[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        aresetn = 1'b1;

        test_name = "reset";
        read_check("crmd", CSR_CRMD);
        check_bit("cpu_interrupt", 1'b0, cpu_interrupt);
        check_bit("idle_over", 1'b0, idle_over);
        read_check("tcfg", CSR_TCFG);
        end_test();

        test_name = "write_readback";
        for (int i = 0; i < 24; i++) begin
            a = pick_addr(rand_bits(3));
            d = rand_bits(32);
            write_csr(a, d);
            read_check(a.name(), a);
            check_word("era port", m_era, era);
            check_word("eentry port", m_eentry, eentry);
        end
        // Pipeline loads of ERA and BADV
        @(negedge clk);
        wen_era  = 1'b1;
        era_in   = rand_bits(32);
        wen_badv = 1'b1;
        badv_in  = rand_bits(32);
        @(negedge clk);
        wen_era  = 1'b0;
        wen_badv = 1'b0;
        m_era    = era_in;
        m_badv   = badv_in;
        check_word("era load", m_era, era);
        read_check("badv load", CSR_BADV);
        read_check("ticlr", CSR_TICLR);
        read_check("unmapped", csr_addr_e'(14'h3ff));
        end_test();

        test_name = "backpressure_flush";
        d = rand_bits(32);
        write_csr(CSR_SAVE1, d);
        n = 1 + int'(rand_bits(3));
        @(negedge clk);
        d_idle = 1'b0;
        wr_req = 1'b1;
        addr   = CSR_SAVE1;
        wdata  = ~d;
        @(negedge clk);
        wr_req = 1'b0;
        repeat (n) read_check("stalled", CSR_SAVE1);
        @(negedge clk);
        d_idle = 1'b1;
        repeat (2) read_check("counting", CSR_SAVE1);
        model_write(CSR_SAVE1, ~d);
        read_check("committed", CSR_SAVE1);
        @(negedge clk);
        wr_req = 1'b1;
        addr   = CSR_SAVE1;
        wdata  = rand_bits(32);
        @(negedge clk);
        wr_req = 1'b0;
        flush  = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (4) read_check("flushed", CSR_SAVE1);
        end_test();

        test_name = "exception";
        for (int i = 0; i < 3; i++) begin
            d = '0;
            d[`CRMD_PLV] = 2'(rand_bits(2)) | 2'b01;
            d[`CRMD_IE]  = 1'b1;
            d[`CRMD_DA]  = 1'b1;
            write_csr(CSR_CRMD, d);
            read_check("crmd before entry", CSR_CRMD);
            raise_exception(7'(rand_bits(7)));
            read_check("crmd after entry", CSR_CRMD);
            read_check("prmd after entry", CSR_PRMD);
            read_check("estat after entry", CSR_ESTAT);
            check_word("crmd port", model_read(CSR_CRMD), crmd);
            return_from_exception();
            read_check("crmd after ertn", CSR_CRMD);
        end
        end_test();

        test_name = "crmd_pg_da";
        for (int i = 0; i < 8; i++) begin
            d = rand_bits(32);
            if (i % 2 == 0) begin
                d[`CRMD_PG] = d[`CRMD_DA];
            end
            write_csr(CSR_CRMD, d);
            read_check("crmd", CSR_CRMD);
            check_word("crmd port", model_read(CSR_CRMD), crmd);
        end
        end_test();

        test_name = "interrupts";
        for (int i = 0; i < 12; i++) begin
            write_csr(CSR_ECFG, rand_bits(32));
            write_csr(CSR_ESTAT, rand_bits(32));
            write_csr(CSR_CRMD, rand_bits(32));
            @(negedge clk);
            hw_int = 8'(rand_bits(8));
            #1;
            pend = model_is();
            check_bit("cpu_interrupt", m_ie && ((m_ecfg & pend) != 13'b0), cpu_interrupt);
            check_bit("idle_over", pend != 13'b0, idle_over);
            read_check("estat", CSR_ESTAT);
        end
        @(negedge clk);
        hw_int = '0;
        end_test();

        test_name = "timer";
        init = 2 + int'(rand_bits(3));
        d = '0;
        d[`TCFG_INITVAL] = 30'(init);
        d[`TCFG_EN]      = 1'b1;
        write_csr(CSR_TCFG, d);
        read_check("tcfg", CSR_TCFG);
        wait_tval('0, init + 8, "one-shot countdown");
        m_ti = 1'b1;
        read_check("estat ti set", CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h1);
        read_check("estat ti cleared", CSR_ESTAT);
        d[`TCFG_PERIODIC] = 1'b1;
        write_csr(CSR_TCFG, d);
        wait_tval('0, init + 8, "periodic countdown");
        m_ti = 1'b1;
        // Zero lasts one cycle before the reload
        @(negedge clk);
        #1;
        check_word("tval reload", csr_word_t'(init), rdata);
        write_csr(CSR_TCFG, 32'h0);
        read_check("estat after periodic", CSR_ESTAT);
        write_csr(CSR_TICLR, 32'h1);
        read_check("estat after disable", CSR_ESTAT);
        end_test();

        $display("%0d tests passed, %0d tests failed, %0d checks, %0d assertion failures",
                 tests_ok, tests_bad, checks, UUT.u_props.failures);
        if (tests_bad == 0 && UUT.u_props.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
